// ==== source/ninjin_defs.svh ====
`ifndef NINJIN_DEFS_SVH
`define NINJIN_DEFS_SVH

// bus and fixed-point widths
`define BWIDTH     32
`define DWIDTH     16
`define DWIDTHLOG  4

// register space, 64 words of 4 bytes
`define REGSIZE    6
`define LSB        2
`define PORT       64

// word map
`define REG_WHICH       0
`define REG_QBITS       2
`define REG_ACC         31
`define REG_QBITS_ECHO  32
`define REG_ROUND       33
`define REG_WHICH_ECHO  63

`endif

// ==== source/ninjin_pkg.sv ====
`include "ninjin_defs.svh"

package ninjin_pkg;

  // one bus word
  typedef logic [`BWIDTH-1:0] word_t;

  // rounded fixed-point result
  typedef logic signed [`DWIDTH-1:0] fixed_t;

  // accumulator as written by the host
  typedef logic signed [`BWIDTH-1:0] acc_t;

  // shift amount
  typedef logic [`DWIDTHLOG-1:0] qbits_t;

  // word index within the register space
  typedef logic [`REGSIZE-1:0] reg_idx_t;

  // lower half of the space, host writable
  typedef word_t param_regs_t [`PORT/2];

  // one requantization job
  typedef struct packed {
    acc_t   acc;
    qbits_t qbits;
  } round_req_t;

endpackage

// ==== source/ninjin_param_if.sv ====
interface ninjin_param_if import ninjin_pkg::*; ();

  param_regs_t regs;
  logic        which;
  qbits_t      qbits;

  // single-cycle job toward the rounder
  logic        acc_valid;
  round_req_t  acc_req;

  modport cfg_src (
    output regs,
    output which,
    output qbits,
    output acc_valid,
    output acc_req
  );

  modport round_sink (
    input  acc_valid,
    input  acc_req
  );

  modport read_sink (
    input  regs,
    input  which,
    input  qbits
  );

endinterface

// ==== source/ninjin_param_write.sv ====
`include "ninjin_defs.svh"

module ninjin_param_write import ninjin_pkg::*; (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic [`REGSIZE+`LSB-1:0]  awaddr,
  input  logic [2:0]                awprot,
  input  logic                      awvalid,
  output logic                      awready,
  input  word_t                     wdata,
  input  logic [`BWIDTH/8-1:0]      wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  ninjin_param_if.cfg_src           param
);

  localparam int NBYTE = `BWIDTH / 8;

  logic                 wr_ready;
  logic                 wr_fire;
  reg_idx_t             wr_idx;
  logic [`REGSIZE-2:0]  wr_slot;
  logic                 wr_param;
  logic                 wr_acc;
  word_t                merged;

  //==============================
  // write handshake
  //==============================

  // aw and w are taken together, one write at a time
  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_ready <= 1'b0;
    end else begin
      wr_ready <= awvalid && wvalid && !bvalid && !wr_ready;
    end
  end

  assign awready = wr_ready;
  assign wready  = wr_ready;
  assign wr_fire = wr_ready && awvalid && wvalid;

  // protection type is not checked, every access is OKAY
  assign bresp = 2'b00;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  //==============================
  // parameter storage
  //==============================

  assign wr_idx   = awaddr[`REGSIZE+`LSB-1:`LSB];
  assign wr_slot  = wr_idx[`REGSIZE-2:0];
  // upper half is read-only
  assign wr_param = !wr_idx[`REGSIZE-1];
  assign wr_acc   = wr_idx == reg_idx_t'(`REG_ACC);

  // byte merge with the stored word
  always_comb begin
    merged = param.regs[wr_slot];
    for (int b = 0; b < NBYTE; b++) begin
      if (wstrb[b]) begin
        merged[8*b +: 8] = wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      for (int i = 0; i < `PORT/2; i++) begin
        param.regs[i] <= '0;
      end
    end else if (wr_fire && wr_param) begin
      param.regs[wr_slot] <= merged;
    end
  end

  assign param.which = param.regs[`REG_WHICH][0];
  assign param.qbits = param.regs[`REG_QBITS][`DWIDTHLOG-1:0];

  //==============================
  // rounding request
  //==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      param.acc_valid <= 1'b0;
    end else begin
      param.acc_valid <= wr_fire && wr_acc;
    end
  end

  // qbits as stored when the accumulator arrives
  always_ff @(posedge clk) begin
    if (wr_fire && wr_acc) begin
      param.acc_req.acc   <= acc_t'(merged);
      param.acc_req.qbits <= param.qbits;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_no_accept_pending: assert property (@(posedge clk) disable iff (!xrst)
    !(awready && bvalid))
    else $error("write accepted while response pending");

endmodule

// ==== source/ninjin_rounder.sv ====
`include "ninjin_defs.svh"

module ninjin_rounder import ninjin_pkg::*; (
  input  logic                clk,
  input  logic                xrst,
  ninjin_param_if.round_sink  param,
  output fixed_t              result,
  output logic                result_valid
);

  logic        s1_valid;
  round_req_t  s1_req;
  logic        s1_neg;
  acc_t        shifted;
  fixed_t      trunc;

  //==============================
  // stage one
  //==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= param.acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (param.acc_valid) begin
      s1_req <= param.acc_req;
      s1_neg <= param.acc_req.acc[`BWIDTH-1];
    end
  end

  //==============================
  // stage two
  //==============================

  // arithmetic shift, keep the low DWIDTH bits
  assign shifted = $signed(s1_req.acc) >>> s1_req.qbits;
  assign trunc   = shifted[`DWIDTH-1:0];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= s1_valid;
    end
  end

  // negative inputs get the minus-one correction
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result <= s1_neg ? trunc - fixed_t'(1) : trunc;
    end
  end

  a_latency: assert property (@(posedge clk) disable iff (!xrst)
    result_valid == $past(param.acc_valid, 2))
    else $error("rounder latency is not two cycles");

endmodule

// ==== source/ninjin_status_read.sv ====
`include "ninjin_defs.svh"

module ninjin_status_read import ninjin_pkg::*; (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic [`REGSIZE+`LSB-1:0]  araddr,
  input  logic [2:0]                arprot,
  input  logic                      arvalid,
  output logic                      arready,
  output word_t                     rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready,
  ninjin_param_if.read_sink         param,
  input  fixed_t                    result,
  input  logic                      result_valid
);

  qbits_t    qbits_q;
  logic      which_q;
  fixed_t    round_q;
  reg_idx_t  rd_idx;
  word_t     rd_word;
  logic      rd_fire;

  //==============================
  // status capture
  //==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      qbits_q <= '0;
      which_q <= 1'b0;
    end else begin
      qbits_q <= param.qbits;
      which_q <= param.which;
    end
  end

  // last rounder output
  always_ff @(posedge clk) begin
    if (!xrst) begin
      round_q <= '0;
    end else if (result_valid) begin
      round_q <= result;
    end
  end

  //==============================
  // read channel
  //==============================

  // one outstanding read, arprot ignored
  assign arready = !rvalid;
  assign rresp   = 2'b00;
  assign rd_fire = arvalid && arready;
  assign rd_idx  = araddr[`REGSIZE+`LSB-1:`LSB];

  always_comb begin
    if (!rd_idx[`REGSIZE-1]) begin
      rd_word = param.regs[rd_idx[`REGSIZE-2:0]];
    end else begin
      case (rd_idx)
        reg_idx_t'(`REG_QBITS_ECHO): rd_word = word_t'(qbits_q);
        reg_idx_t'(`REG_ROUND):      rd_word = {{(`BWIDTH-`DWIDTH){round_q[`DWIDTH-1]}}, round_q};
        reg_idx_t'(`REG_WHICH_ECHO): rd_word = word_t'(which_q);
        default:                     rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
    end
  end

  a_rdata_stable: assert property (@(posedge clk) disable iff (!xrst)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("read response changed under back-pressure");

endmodule

// ==== source/ninjin_top.sv ====
`include "ninjin_defs.svh"

module ninjin_top import ninjin_pkg::*; (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic [`REGSIZE+`LSB-1:0]  awaddr,
  input  logic [2:0]                awprot,
  input  logic                      awvalid,
  output logic                      awready,
  input  word_t                     wdata,
  input  logic [`BWIDTH/8-1:0]      wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [1:0]                bresp,
  output logic                      bvalid,
  input  logic                      bready,
  input  logic [`REGSIZE+`LSB-1:0]  araddr,
  input  logic [2:0]                arprot,
  input  logic                      arvalid,
  output logic                      arready,
  output word_t                     rdata,
  output logic [1:0]                rresp,
  output logic                      rvalid,
  input  logic                      rready
);

  fixed_t  result;
  logic    result_valid;

  ninjin_param_if param_bus ();

  ninjin_param_write ninjin_param_write_inst (
    .clk     (clk),
    .xrst    (xrst),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .param   (param_bus.cfg_src)
  );

  ninjin_rounder ninjin_rounder_inst (
    .clk          (clk),
    .xrst         (xrst),
    .param        (param_bus.round_sink),
    .result       (result),
    .result_valid (result_valid)
  );

  ninjin_status_read ninjin_status_read_inst (
    .clk          (clk),
    .xrst         (xrst),
    .araddr       (araddr),
    .arprot       (arprot),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .param        (param_bus.read_sink),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// ==== verif/ninjin_tb.sv ====
`include "ninjin_defs.svh"

module ninjin_tb import ninjin_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TXN_COUNT = 1310;
  localparam int HS_LIMIT  = 64;

  logic        clk;
  logic        xrst;
  logic [7:0]  awaddr;
  logic [2:0]  awprot;
  logic        awvalid;
  logic        awready;
  word_t       wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic [2:0]  arprot;
  logic        arvalid;
  logic        arready;
  word_t       rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  logic [31:0] lfsr_state = 32'h2f3d;
  word_t       shadow [32];
  word_t       last_round;
  int          passes;
  int          fails;

  ninjin_top ninjin_top_inst (.*);

  always #20 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  //==============================
  // reference model
  //==============================

  // shift right by qbits, keep 16 bits, negative inputs one lower
  function automatic word_t round_model(input word_t acc, input logic [3:0] q);
    logic signed [31:0] sacc;
    logic signed [31:0] shifted;
    logic [15:0]        low;
    sacc    = acc;
    shifted = sacc >>> q;
    low     = shifted[15:0];
    if (acc[31]) begin
      low = low - 16'd1;
    end
    return {{16{low[15]}}, low};
  endfunction

  function automatic void model_write(input int idx, input word_t data, input logic [3:0] strb);
    if (idx < 32) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          shadow[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
      if (idx == `REG_ACC) begin
        last_round = round_model(shadow[`REG_ACC], shadow[`REG_QBITS][3:0]);
      end
    end
  endfunction

  function automatic word_t expected_word(input int idx);
    if (idx < 32) begin
      return shadow[idx];
    end
    case (idx)
      `REG_QBITS_ECHO: return {28'b0, shadow[`REG_QBITS][3:0]};
      `REG_ROUND:      return last_round;
      `REG_WHICH_ECHO: return {31'b0, shadow[`REG_WHICH][0]};
      default:         return '0;
    endcase
  endfunction

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp) passes++;
    else begin
      $display("mismatch at %0t: %s read %08h, expected %08h", $time, what, got, exp);
      fails++;
    end
  endtask

  task automatic check_flag(input logic ok, input string what);
    assert (ok) passes++;
    else begin
      $display("at %0t the %s", $time, what);
      fails++;
    end
  endtask

  //==============================
  // bus tasks
  //==============================

  task automatic write_word(input int idx, input word_t data, input logic [3:0] strb,
                            input int stall);
    int   waited;
    logic seen;
    @(posedge clk);
    #2;
    awaddr  = 8'(idx << 2);
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    do begin
      @(negedge clk);
      seen = awready && wready;
      check_flag(awready == wready, "awready and wready were not raised together");
      @(posedge clk);
      waited++;
    end while (!seen && waited < HS_LIMIT);
    check_flag(seen, "write address and data were never accepted");
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!seen) return;
    model_write(idx, data, strb);
    repeat (stall) begin
      @(negedge clk);
      check_flag(bvalid && bresp == 2'b00, "write response dropped or not OKAY under stall");
      @(posedge clk);
      #2;
    end
    bready = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      seen = bvalid;
      if (seen) check_flag(bresp == 2'b00, "write response was not OKAY");
      @(posedge clk);
      waited++;
    end while (!seen && waited < HS_LIMIT);
    check_flag(seen, "write response never arrived");
    #2;
    bready = 1'b0;
  endtask

  task automatic read_word(input int idx, input int stall, output word_t data);
    int    waited;
    logic  seen;
    logic  have;
    word_t held;
    @(posedge clk);
    #2;
    araddr  = 8'(idx << 2);
    arvalid = 1'b1;
    waited  = 0;
    do begin
      @(negedge clk);
      seen = arready;
      @(posedge clk);
      waited++;
    end while (!seen && waited < HS_LIMIT);
    check_flag(seen, "read address was never accepted");
    #2;
    arvalid = 1'b0;
    data    = '0;
    if (!seen) return;
    have = 1'b0;
    held = '0;
    repeat (stall) begin
      @(negedge clk);
      check_flag(rvalid && rresp == 2'b00 && (!have || rdata == held),
                 "read response dropped or changed under stall");
      held = rdata;
      have = 1'b1;
      @(posedge clk);
      #2;
    end
    rready = 1'b1;
    waited = 0;
    do begin
      @(negedge clk);
      seen = rvalid;
      if (seen) begin
        data = rdata;
        check_flag(rresp == 2'b00, "read response was not OKAY");
      end
      @(posedge clk);
      waited++;
    end while (!seen && waited < HS_LIMIT);
    check_flag(seen, "read response never arrived");
    if (have) check_flag(data == held, "read data changed when rready rose");
    #2;
    rready = 1'b0;
  endtask

  task automatic read_check(input int idx, input int stall);
    word_t got;
    read_word(idx, stall, got);
    check_word($sformatf("word %0d", idx), got, expected_word(idx));
  endtask

  task automatic round_trial(input logic [3:0] q, input word_t acc, input int stall);
    word_t qword;
    qword      = next_bits(32);
    qword[3:0] = q;
    write_word(`REG_QBITS, qword, 4'hf, stall);
    write_word(`REG_ACC, acc, 4'hf, stall);
    // result lands three cycles after the accumulator write
    repeat (4) @(posedge clk);
    read_check(`REG_ROUND, stall);
  endtask

  task automatic report_test(input string name, input int base);
    $display("test %-14s done, %0d failures", name, fails - base);
  endtask

  //==============================
  // test sequence
  //==============================

  initial begin
    int          base;
    int          idx;
    word_t       acc;
    logic [3:0]  q;
    clk     = 1'b0;
    xrst    = 1'b0;
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    last_round = '0;
    passes     = 0;
    fails      = 0;
    repeat (4) @(posedge clk);
    #2;
    xrst = 1'b1;

    base = fails;
    @(negedge clk);
    check_flag(!awready && !wready && !bvalid && !rvalid && arready,
               "handshake outputs were not at reset values");
    read_check(0, 0);
    read_check(31, 0);
    read_check(32, 0);
    read_check(33, 0);
    read_check(40, 0);
    read_check(63, 0);
    report_test("reset", base);

    base = fails;
    repeat (100) begin
      idx = next_bits(5) % 31;
      write_word(idx, next_bits(32), next_bits(4), 0);
      read_check(idx, 0);
    end
    // upper half ignores writes
    repeat (20) begin
      idx = 32 + next_bits(5);
      write_word(idx, next_bits(32), 4'hf, 0);
      read_check(idx, 0);
    end
    for (int i = 0; i < 32; i++) read_check(i, 0);
    report_test("readback", base);

    base = fails;
    for (int i = 0; i < 200; i++) begin
      q   = (i == 0) ? 4'd0 : (i == 1) ? 4'd15 : 4'(next_bits(4));
      acc = next_bits(32);
      if (i % 3 == 0) acc[31] = 1'b1;
      round_trial(q, acc, 0);
    end
    report_test("rounding", base);

    base = fails;
    repeat (20) begin
      write_word(`REG_WHICH, next_bits(32), next_bits(4), 0);
      write_word(`REG_QBITS, next_bits(32), next_bits(4), 0);
      read_check(`REG_WHICH_ECHO, 0);
      read_check(`REG_QBITS_ECHO, 0);
    end
    report_test("echo", base);

    base = fails;
    repeat (100) begin
      idx = next_bits(6);
      write_word(idx, next_bits(32), next_bits(4), next_bits(3));
      repeat (4) @(posedge clk);
      read_check(next_bits(6), next_bits(3));
    end
    repeat (50) round_trial(next_bits(4), next_bits(32), next_bits(3));
    report_test("backpressure", base);

    $display("checks passed %0d, failed %0d", passes, fails);
    if (fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // forty cycles per transaction
  initial begin
    #(TXN_COUNT * 40 * 40);
    $display("watchdog expired at %0t, the bus stopped making progress", $time);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/ninjin_pkg.sv
source/ninjin_param_if.sv
source/ninjin_param_write.sv
source/ninjin_rounder.sv
source/ninjin_status_read.sv
source/ninjin_top.sv
verif/ninjin_tb.sv

// ==== Bender.yml ====
package:
  name: ninjin

export_include_dirs:
  - source

sources:
  # design
  - include_dirs:
      - source
    files:
      - source/ninjin_pkg.sv
      - source/ninjin_param_if.sv
      - source/ninjin_param_write.sv
      - source/ninjin_rounder.sv
      - source/ninjin_status_read.sv
      - source/ninjin_top.sv
  # testbench
  - target: test
    include_dirs:
      - source
    files:
      - verif/ninjin_tb.sv
